// ==== vlog.f ====
source/lc4_pkg.sv
source/lc4_fetch.sv
source/lc4_decoder.sv
source/lc4_regfile.sv
source/lc4_decode.sv
source/lc4_execute.sv
source/lc4_memwb.sv
source/lc4_core.sv
verif/lc4_core_properties.sv
verif/lc4_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --assert -Wno-fatal
TOP      := lc4_tb
FILELIST := vlog.f

PASS_MSG := Result: PASSED
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/lc4_tb.sv ====
/* testbench for the LC4 subset core, fixed program with random CONST values
   memories answer combinationally, an ISA model predicts every retire and store */
`timescale 1ns/10ps

module lc4_tb
    import lc4_pkg::*;
();

    localparam int RST_CYCLES = 16;

    logic      gwe = 1'b0;
    logic      i_rst;
    word_t     o_pc;
    insn_u     insn;
    dmem_req_t o_dmem_req;
    word_t     dmem_data;
    retire_t   o_retire;

    word_t     imem [512];
    word_t     dmem [256];
    word_t     dmem_model [256];
    retire_t   exp_retire [$];
    dmem_req_t exp_store [$];
    logic [31:0] lfsr_state = 32'h8932;
    int        prog_len = 0;
    int        mismatches = 0;
    int        other_errors = 0;
    int        retired = 0;
    int        stored = 0;

    always #2 gwe = ~gwe;

    lc4_core uut (
        .gwe         (gwe),
        .i_rst       (i_rst),
        .o_pc        (o_pc),
        .i_insn      (insn),
        .o_dmem_req  (o_dmem_req),
        .i_dmem_data (dmem_data),
        .o_retire    (o_retire)
    );

    bind lc4_core lc4_core_properties u_props (
        .gwe        (gwe),
        .i_rst      (i_rst),
        .i_pc       (o_pc),
        .i_dmem_req (o_dmem_req),
        .i_retire   (o_retire),
        .i_stall    (stall),
        .i_redirect (redirect),
        .i_fd       (fd),
        .i_dx       (dx)
    );

    // program space starts at the reset pc, 512 words wrap on pc[8:0]
    assign insn      = imem[o_pc[8:0]];
    assign dmem_data = dmem[o_dmem_req.addr[7:0]];

    always @(posedge gwe) begin
        if (o_dmem_req.we === 1'b1) begin
            dmem[o_dmem_req.addr[7:0]] <= o_dmem_req.wdata;
        end
    end

    // Galois form, taps of a maximal 32-bit polynomial
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic int random_imm9();
        logic [8:0] v;
        for (int k = 0; k < 9; k++) begin
            v[k]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return int'(v);
    endfunction

    // every data word differs with every address bit
    function automatic word_t fill_word(input logic [7:0] a);
        return {a ^ 8'hA5, ~a};
    endfunction

    // instruction encoders
    function automatic word_t alu_reg(input logic [3:0] op, input int rd, input int rs,
                                      input int rt);
        return {op, rd[2:0], rs[2:0], 3'b000, rt[2:0]};
    endfunction

    function automatic word_t alu_imm(input logic [3:0] op, input int rd, input int rs,
                                      input int imm);
        return {op, rd[2:0], rs[2:0], 1'b1, imm[4:0]};
    endfunction

    function automatic word_t mem_op(input logic [3:0] op, input int r, input int rs,
                                     input int off);
        return {op, r[2:0], rs[2:0], off[5:0]};
    endfunction

    function automatic word_t const_op(input int rd, input int imm);
        return {OP_CONST, rd[2:0], imm[8:0]};
    endfunction

    function automatic word_t br_op(input logic [2:0] mask, input int off);
        return {OP_BR, mask, off[8:0]};
    endfunction

    function automatic word_t jmp_op(input int off);
        return {OP_JMP, 1'b1, off[10:0]};
    endfunction

    task automatic emit(input word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        for (int a = 0; a < 512; a++) begin
            // zero word is BR with an empty mask, a nop
            imem[a] = '0;
        end
        for (int a = 0; a < 256; a++) begin
            dmem[a]       = fill_word(a[7:0]);
            dmem_model[a] = fill_word(a[7:0]);
        end
        // dependent alu chain, MX and WX bypass
        emit(const_op(1, random_imm9()));
        emit(const_op(2, random_imm9()));
        emit(alu_reg(OP_ADD, 3, 1, 2));
        emit(alu_reg(OP_AND, 4, 3, 1));
        emit(alu_imm(OP_ADD, 5, 4, -3));
        emit(alu_imm(OP_AND, 6, 5, 13));
        emit(const_op(0, 16));
        emit(mem_op(OP_STR, 5, 0, 0));
        emit(alu_reg(OP_ADD, 7, 6, 3));
        // store data from the instruction right before
        emit(mem_op(OP_STR, 7, 0, 1));
        // load-use pair
        emit(mem_op(OP_LDR, 1, 0, 0));
        emit(alu_reg(OP_ADD, 2, 1, 1));
        // store data straight from a load, WM bypass
        emit(mem_op(OP_LDR, 3, 0, 1));
        emit(mem_op(OP_STR, 3, 0, 2));
        // branches after CONST
        emit(const_op(4, -1));
        emit(br_op(3'b010, 2));
        emit(br_op(3'b100, 2));
        emit(alu_imm(OP_ADD, 6, 6, 1));
        emit(alu_imm(OP_ADD, 6, 6, 2));
        emit(const_op(4, 0));
        emit(br_op(3'b001, 2));
        emit(br_op(3'b010, 2));
        emit(alu_imm(OP_ADD, 6, 6, 3));
        emit(alu_imm(OP_ADD, 6, 6, 4));
        emit(mem_op(OP_STR, 4, 0, 4));
        emit(const_op(5, 7));
        emit(br_op(3'b100, 2));
        emit(br_op(3'b001, 2));
        emit(alu_imm(OP_ADD, 5, 5, 1));
        emit(alu_imm(OP_ADD, 5, 5, 2));
        // branches right after a load, negative then zero
        emit(mem_op(OP_LDR, 6, 0, 3));
        emit(br_op(3'b100, 2));
        emit(alu_imm(OP_ADD, 6, 6, 5));
        emit(alu_imm(OP_ADD, 6, 6, 6));
        emit(mem_op(OP_LDR, 7, 0, 4));
        emit(br_op(3'b001, 2));
        emit(br_op(3'b010, 2));
        emit(alu_imm(OP_ADD, 7, 7, 1));
        emit(alu_imm(OP_ADD, 7, 7, 2));
        emit(jmp_op(2));
        emit(alu_imm(OP_ADD, 1, 1, 1));
        emit(alu_imm(OP_ADD, 1, 1, 2));
        emit(alu_reg(OP_ADD, 1, 2, 3));
        emit(alu_imm(OP_AND, 2, 1, -1));
        emit(mem_op(OP_STR, 2, 0, 5));
        emit(alu_reg(OP_ADD, 3, 2, 7));
    endtask

    // in-order ISA model, fills the expected retire and store queues
    task automatic run_model();
        word_t      regs [8];
        word_t      pc;
        word_t      w;
        word_t      val;
        word_t      addr;
        word_t      next_pc;
        logic [2:0] nzp;
        logic       wr;
        retire_t    r;
        dmem_req_t  s;
        int         steps;
        for (int k = 0; k < 8; k++) begin
            regs[k] = '0;
        end
        nzp   = '0;
        pc    = RESET_PC;
        steps = 0;
        while (int'(pc - RESET_PC) < prog_len && steps < 1000) begin
            w       = imem[pc[8:0]];
            val     = '0;
            wr      = 1'b0;
            next_pc = pc + 16'd1;
            // base plus signed 6-bit offset
            addr = regs[w[8:6]] + {{10{w[5]}}, w[5:0]};
            case (w[15:12])
                OP_ADD: begin
                    val = regs[w[8:6]] + (w[5] ? {{11{w[4]}}, w[4:0]} : regs[w[2:0]]);
                    wr  = 1'b1;
                end
                OP_AND: begin
                    val = regs[w[8:6]] & (w[5] ? {{11{w[4]}}, w[4:0]} : regs[w[2:0]]);
                    wr  = 1'b1;
                end
                OP_CONST: begin
                    val = {{7{w[8]}}, w[8:0]};
                    wr  = 1'b1;
                end
                OP_LDR: begin
                    val = dmem_model[addr[7:0]];
                    wr  = 1'b1;
                end
                OP_STR: begin
                    s.we    = 1'b1;
                    s.addr  = addr;
                    s.wdata = regs[w[11:9]];
                    exp_store.push_back(s);
                    dmem_model[addr[7:0]] = regs[w[11:9]];
                end
                OP_BR: begin
                    if ((w[11:9] & nzp) != 3'b000) begin
                        next_pc = pc + 16'd1 + {{7{w[8]}}, w[8:0]};
                    end
                end
                OP_JMP: begin
                    if (w[11]) begin
                        next_pc = pc + 16'd1 + {{5{w[10]}}, w[10:0]};
                    end
                end
                default: begin
                    wr = 1'b0;
                end
            endcase
            if (wr) begin
                regs[w[11:9]] = val;
                nzp = val[15] ? 3'b100 : ((val == '0) ? 3'b010 : 3'b001);
            end
            r        = '0;
            r.valid  = 1'b1;
            r.pc     = pc;
            r.insn   = w;
            r.reg_we = wr;
            r.wsel   = w[11:9];
            r.wdata  = val;
            r.nzp_we = wr;
            r.nzp    = nzp;
            exp_retire.push_back(r);
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t got);
        assert (got === exp) else begin
            mismatches++;
            $display("FAIL %s expected %h actual %h", name, exp, got);
        end
    endtask

    // outputs settle after the rising edge, sampled on the falling one
    always @(negedge gwe) begin : compare_outputs
        retire_t   e;
        dmem_req_t s;
        if (o_retire.valid === 1'b1 && exp_retire.size() != 0) begin
            e = exp_retire.pop_front();
            check_value($sformatf("trace %0d pc", retired), e.pc, o_retire.pc);
            check_value($sformatf("trace %0d insn", retired), e.insn, o_retire.insn);
            check_value($sformatf("trace %0d reg_we", retired), word_t'(e.reg_we),
                        word_t'(o_retire.reg_we));
            check_value($sformatf("trace %0d nzp_we", retired), word_t'(e.nzp_we),
                        word_t'(o_retire.nzp_we));
            if (e.reg_we) begin
                check_value($sformatf("trace %0d wsel", retired), word_t'(e.wsel),
                            word_t'(o_retire.wsel));
                check_value($sformatf("trace %0d wdata", retired), e.wdata, o_retire.wdata);
            end
            if (e.nzp_we) begin
                check_value($sformatf("trace %0d nzp", retired), word_t'(e.nzp),
                            word_t'(o_retire.nzp));
            end
            retired++;
        end
        if (o_dmem_req.we === 1'b1) begin
            if (exp_store.size() == 0) begin
                other_errors++;
                $display("store to address %h that the program never makes", o_dmem_req.addr);
            end else begin
                s = exp_store.pop_front();
                check_value($sformatf("store %0d addr", stored), s.addr, o_dmem_req.addr);
                check_value($sformatf("store %0d data", stored), s.wdata, o_dmem_req.wdata);
                stored++;
            end
        end
    end

    // bound on run length, eight cycles per instruction is far above the worst case
    initial begin
        #1;
        repeat (RST_CYCLES + prog_len * 8) @(posedge gwe);
        $display("timeout: the core stopped retiring after %0d of the program's instructions",
                 retired);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        i_rst = 1'b1;
        build_program();
        run_model();
        repeat (RST_CYCLES) @(negedge gwe);
        i_rst = 1'b0;
        while (exp_retire.size() != 0) begin
            @(negedge gwe);
        end
        @(negedge gwe);
        if (exp_store.size() != 0) begin
            other_errors++;
            $display("%0d stores of the program were never issued", exp_store.size());
        end
        $display("errors: %0d mismatch, %0d other, %0d assertion", mismatches, other_errors,
                 uut.u_props.fail_count);
        if (mismatches == 0 && other_errors == 0 && uut.u_props.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/lc4_core_properties.sv ====
/* concurrent checks on the core, sampled on the rising clock edge
   load-use spacing holds because a load in execute never redirects */
`timescale 1ns/10ps

module lc4_core_properties
    import lc4_pkg::*;
(
    input logic      gwe,
    input logic      i_rst,
    input word_t     i_pc,
    input dmem_req_t i_dmem_req,
    input retire_t   i_retire,
    input logic      i_stall,
    input redirect_t i_redirect,
    input stage_t    i_fd,
    input stage_t    i_dx
);

    int unsigned fail_count = 0;
    logic        retire_load;

    assign retire_load = i_retire.valid && i_retire.insn.r.opcode == OP_LDR;

    // state after every reset edge, also one cycle past reset
    assert property (@(posedge gwe) $past(i_rst) |->
                     i_pc == RESET_PC && !i_dmem_req.we && !i_retire.valid &&
                     !i_fd.valid && !i_dx.valid)
        else begin
            fail_count++;
            $error("core state after reset is not the reset state");
        end

    // load retires, one empty retire slot, then the dependent one
    assert property (@(posedge gwe) disable iff (i_rst) $past(i_stall, 4) |->
                     i_retire.valid && !$past(i_retire.valid) && $past(retire_load, 2))
        else begin
            fail_count++;
            $error("retire spacing after a load-use pair is not exactly one bubble");
        end

    // branch retires, two squashed slots, then the target five cycles after resolve
    assert property (@(posedge gwe) disable iff (i_rst) $past(i_redirect.taken, 5) |->
                     i_retire.valid && i_retire.pc == $past(i_redirect.target, 5) &&
                     !$past(i_retire.valid) && !$past(i_retire.valid, 2))
        else begin
            fail_count++;
            $error("target of a taken redirect did not retire right after two empty slots");
        end

    assert property (@(posedge gwe) disable iff (i_rst) i_dmem_req.we |->
                     !$isunknown({i_dmem_req.addr, i_dmem_req.wdata}))
        else begin
            fail_count++;
            $error("store request with unknown address or data");
        end

endmodule

// ==== source/lc4_core.sv ====
/* five-stage LC4 subset core, both memories external and combinational
   an unstalled instruction retires four cycles after its fetch */
`timescale 1ns/10ps

module lc4_core
    import lc4_pkg::*;
(
    input  logic      gwe,
    input  logic      i_rst,
    output word_t     o_pc,
    input  insn_u     i_insn,
    output dmem_req_t o_dmem_req,
    input  word_t     i_dmem_data,
    output retire_t   o_retire
);

    stage_t           fd;
    stage_t           dx;
    stage_t           xm;
    word_t            dx_rs_data;
    word_t            dx_rt_data;
    word_t            xm_result;
    word_t            xm_store_data;
    redirect_t        redirect;
    logic             stall;
    fwd_t             m_fwd;
    fwd_t             w_fwd;
    logic [NZP_W-1:0] nzp;

    lc4_fetch u_fetch (
        .i_rst      (i_rst),
        .gwe        (gwe),
        .i_stall    (stall),
        .i_redirect (redirect),
        .i_insn     (i_insn),
        .o_pc       (o_pc),
        .o_fd       (fd)
    );

    // write-back value doubles as the regfile write port
    lc4_decode u_decode (
        .gwe        (gwe),
        .i_rst      (i_rst),
        .i_fd       (fd),
        .i_redirect (redirect),
        .i_wr       (w_fwd),
        .o_stall    (stall),
        .o_dx       (dx),
        .o_rs_data  (dx_rs_data),
        .o_rt_data  (dx_rt_data)
    );

    lc4_execute u_execute (
        .gwe          (gwe),
        .i_rst        (i_rst),
        .i_dx         (dx),
        .i_rs_data    (dx_rs_data),
        .i_rt_data    (dx_rt_data),
        .i_m_fwd      (m_fwd),
        .i_w_fwd      (w_fwd),
        .i_nzp        (nzp),
        .o_redirect   (redirect),
        .o_xm         (xm),
        .o_result     (xm_result),
        .o_store_data (xm_store_data)
    );

    lc4_memwb u_memwb (
        .gwe          (gwe),
        .i_rst        (i_rst),
        .i_xm         (xm),
        .i_result     (xm_result),
        .i_store_data (xm_store_data),
        .i_dmem_data  (i_dmem_data),
        .o_dmem_req   (o_dmem_req),
        .o_m_fwd      (m_fwd),
        .o_w_fwd      (w_fwd),
        .o_nzp        (nzp),
        .o_retire     (o_retire)
    );

endmodule

// ==== source/lc4_memwb.sv ====
/* memory and write-back stages with WM store-data bypass and the NZP register
   data memory must answer in the same cycle, retire trace is one cycle after memory */
`timescale 1ns/10ps

module lc4_memwb
    import lc4_pkg::*;
(
    input  logic             gwe,
    input  logic             i_rst,
    input  stage_t           i_xm,
    input  word_t            i_result,
    input  word_t            i_store_data,
    input  word_t            i_dmem_data,
    output dmem_req_t        o_dmem_req,
    output fwd_t             o_m_fwd,
    output fwd_t             o_w_fwd,
    output logic [NZP_W-1:0] o_nzp,
    output retire_t          o_retire
);

    word_t            mem_value;
    logic [NZP_W-1:0] m_nzp;
    logic [NZP_W-1:0] nzp_q;
    stage_t           w_q;
    word_t            w_result_q;
    word_t            w_load_q;
    logic [NZP_W-1:0] w_nzp_q;
    word_t            w_data;

    function automatic logic [NZP_W-1:0] nzp_of(input word_t v);
        if (v[WORD_W-1]) return 3'b100;
        if (v == '0) return 3'b010;
        return 3'b001;
    endfunction

    // a load directly ahead of a store feeds it from write-back
    assign o_dmem_req.we    = i_xm.valid && i_xm.ctrl.is_store;
    assign o_dmem_req.addr  = i_result;
    assign o_dmem_req.wdata = (o_w_fwd.we && o_w_fwd.sel == i_xm.ctrl.rt) ? w_data
                                                                          : i_store_data;

    // load condition comes straight from memory data, no branch stall needed
    assign mem_value = i_xm.ctrl.is_load ? i_dmem_data : i_result;
    assign m_nzp     = nzp_of(mem_value);
    assign o_nzp     = (i_xm.valid && i_xm.ctrl.nzp_we) ? m_nzp : nzp_q;

    // load data is not ready for execute, loads stay off this path
    assign o_m_fwd.we   = i_xm.valid && i_xm.ctrl.reg_we && !i_xm.ctrl.is_load;
    assign o_m_fwd.sel  = i_xm.ctrl.rd;
    assign o_m_fwd.data = i_result;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            nzp_q     <= '0;
            w_q.valid <= 1'b0;
        end else begin
            if (i_xm.valid && i_xm.ctrl.nzp_we) begin
                nzp_q <= m_nzp;
            end
            w_q        <= i_xm;
            w_result_q <= i_result;
            w_load_q   <= i_dmem_data;
            w_nzp_q    <= m_nzp;
        end
    end

    assign w_data = w_q.ctrl.is_load ? w_load_q : w_result_q;

    // also the regfile write port
    assign o_w_fwd.we   = w_q.valid && w_q.ctrl.reg_we;
    assign o_w_fwd.sel  = w_q.ctrl.rd;
    assign o_w_fwd.data = w_data;

    assign o_retire.valid  = w_q.valid;
    assign o_retire.pc     = w_q.pc;
    assign o_retire.insn   = w_q.insn;
    assign o_retire.reg_we = o_w_fwd.we;
    assign o_retire.wsel   = w_q.ctrl.rd;
    assign o_retire.wdata  = w_data;
    assign o_retire.nzp_we = w_q.valid && w_q.ctrl.nzp_we;
    assign o_retire.nzp    = w_nzp_q;

endmodule

// ==== source/lc4_execute.sv ====
/* execute stage with MX/WX operand bypass, ALU and branch resolution
   the redirect is combinational, target and result share one adder output */
`timescale 1ns/10ps

module lc4_execute
    import lc4_pkg::*;
(
    input  logic             gwe,
    input  logic             i_rst,
    input  stage_t           i_dx,
    input  word_t            i_rs_data,
    input  word_t            i_rt_data,
    input  fwd_t             i_m_fwd,
    input  fwd_t             i_w_fwd,
    input  logic [NZP_W-1:0] i_nzp,
    output redirect_t        o_redirect,
    output stage_t           o_xm,
    output word_t            o_result,
    output word_t            o_store_data
);

    word_t  rs_val;
    word_t  rt_val;
    word_t  pc_inc;
    word_t  imm5_sx;
    word_t  off6_sx;
    word_t  off9_sx;
    word_t  off11_sx;
    word_t  alu_b;
    word_t  result;
    stage_t xm_q;
    word_t  result_q;
    word_t  store_q;

    // memory stage is younger than write-back, so it wins
    function automatic word_t bypass(input logic [REG_SEL_W-1:0] sel, input logic re,
                                     input fwd_t m, input fwd_t w, input word_t rf);
        if (re && m.we && m.sel == sel) return m.data;
        if (re && w.we && w.sel == sel) return w.data;
        return rf;
    endfunction

    assign rs_val = bypass(i_dx.ctrl.rs, i_dx.ctrl.rs_re, i_m_fwd, i_w_fwd, i_rs_data);
    assign rt_val = bypass(i_dx.ctrl.rt, i_dx.ctrl.rt_re, i_m_fwd, i_w_fwd, i_rt_data);

    // sign-extended immediates
    assign imm5_sx  = {{11{i_dx.insn.i.imm5[4]}}, i_dx.insn.i.imm5};
    // ldr/str offset spans the flag bit too
    assign off6_sx  = {{10{i_dx.insn.i.imm_flag}}, i_dx.insn.i.imm_flag, i_dx.insn.i.imm5};
    assign off9_sx  = {{7{i_dx.insn.b.off9[8]}}, i_dx.insn.b.off9};
    // jmp offset runs into the low two mask bits
    assign off11_sx = {{5{i_dx.insn.b.nzp[1]}}, i_dx.insn.b.nzp[1:0], i_dx.insn.b.off9};

    assign pc_inc = i_dx.pc + word_t'(1);
    assign alu_b  = i_dx.insn.i.imm_flag ? imm5_sx : rt_val;

    always_comb begin
        case (i_dx.insn.r.opcode)
            OP_ADD:         result = rs_val + alu_b;
            OP_AND:         result = rs_val & alu_b;
            OP_CONST:       result = off9_sx;
            OP_LDR, OP_STR: result = rs_val + off6_sx;
            OP_BR:          result = pc_inc + off9_sx;
            OP_JMP:         result = pc_inc + off11_sx;
            default:        result = '0;
        endcase
    end

    // i_nzp already reflects the instruction in the memory stage
    assign o_redirect.taken  = i_dx.valid && (i_dx.ctrl.is_jump ||
                               (i_dx.ctrl.is_branch && |(i_dx.insn.b.nzp & i_nzp)));
    assign o_redirect.target = result;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            xm_q.valid <= 1'b0;
        end else begin
            // the branch itself moves on and retires
            xm_q     <= i_dx;
            result_q <= result;
            store_q  <= rt_val;
        end
    end

    assign o_xm         = xm_q;
    assign o_result     = result_q;
    assign o_store_data = store_q;

endmodule

// ==== source/lc4_decode.sv ====
/* decode stage with register read, load-use stall and the decode/execute register
   stall lasts one cycle per load-use pair, store data from a load is bypassed later */
`timescale 1ns/10ps

module lc4_decode
    import lc4_pkg::*;
(
    input  logic      gwe,
    input  logic      i_rst,
    input  stage_t    i_fd,
    input  redirect_t i_redirect,
    input  fwd_t      i_wr,
    output logic      o_stall,
    output stage_t    o_dx,
    output word_t     o_rs_data,
    output word_t     o_rt_data
);

    ctrl_t  ctrl;
    word_t  rs_data;
    word_t  rt_data;
    logic   rs_hit;
    logic   rt_hit;
    stage_t dx_q;
    word_t  rs_q;
    word_t  rt_q;

    lc4_decoder u_decoder (
        .i_insn (i_fd.insn),
        .o_ctrl (ctrl)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .i_rs      (ctrl.rs),
        .i_rt      (ctrl.rt),
        .i_wr      (i_wr),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    // load sitting in execute, its data exists only after the memory stage
    assign rs_hit = ctrl.rs_re && ctrl.rs == dx_q.ctrl.rd;
    // a store's data operand can wait for the WM bypass
    assign rt_hit = ctrl.rt_re && !ctrl.is_store && ctrl.rt == dx_q.ctrl.rd;
    assign o_stall = i_fd.valid && dx_q.valid && dx_q.ctrl.is_load && (rs_hit || rt_hit);

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            dx_q.valid <= 1'b0;
        end else if (i_redirect.taken || o_stall) begin
            // bubble into execute
            dx_q.valid <= 1'b0;
        end else begin
            dx_q <= '{valid: i_fd.valid, pc: i_fd.pc, insn: i_fd.insn, ctrl: ctrl};
            rs_q <= rs_data;
            rt_q <= rt_data;
        end
    end

    assign o_dx      = dx_q;
    assign o_rs_data = rs_q;
    assign o_rt_data = rt_q;

endmodule

// ==== source/lc4_regfile.sv ====
/* eight 16-bit registers, two read ports and one write port
   a read of the register being written returns the new data */
`timescale 1ns/10ps

module lc4_regfile
    import lc4_pkg::*;
(
    input  logic                 gwe,
    input  logic                 i_rst,
    input  logic [REG_SEL_W-1:0] i_rs,
    input  logic [REG_SEL_W-1:0] i_rt,
    input  fwd_t                 i_wr,
    output word_t                o_rs_data,
    output word_t                o_rt_data
);

    word_t regs [2**REG_SEL_W];

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < 2**REG_SEL_W; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr.we) begin
            regs[i_wr.sel] <= i_wr.data;
        end
    end

    // write-through covers the write-back to decode distance
    assign o_rs_data = (i_wr.we && i_wr.sel == i_rs) ? i_wr.data : regs[i_rs];
    assign o_rt_data = (i_wr.we && i_wr.sel == i_rt) ? i_wr.data : regs[i_rt];

endmodule

// ==== source/lc4_decoder.sv ====
/* combinational decode of the supported LC4 subset
   anything outside it, JMPR and non-zero ADD/AND sub-ops included, decodes to no effect */
`timescale 1ns/10ps

module lc4_decoder
    import lc4_pkg::*;
(
    input  insn_u i_insn,
    output ctrl_t o_ctrl
);

    always_comb begin
        o_ctrl = '0;
        // register fields sit in the same place in every format
        o_ctrl.rd = i_insn.r.rd;
        o_ctrl.rs = i_insn.r.rs;
        o_ctrl.rt = i_insn.r.rt;
        case (i_insn.r.opcode)
            OP_ADD, OP_AND: begin
                if (i_insn.i.imm_flag) begin
                    // immediate form reads rs only
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.reg_we = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                end else if (i_insn.r.sub == 3'b000) begin
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rt_re  = 1'b1;
                    o_ctrl.reg_we = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                end
            end
            OP_CONST: begin
                o_ctrl.reg_we = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end
            OP_BR: begin
                // mask of 000 never takes, acts as a nop
                o_ctrl.is_branch = 1'b1;
            end
            OP_JMP: begin
                // bit 11 set is the pc-relative form
                o_ctrl.is_jump = i_insn.b.nzp[2];
            end
            OP_LDR: begin
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.reg_we  = 1'b1;
                o_ctrl.nzp_we  = 1'b1;
                o_ctrl.is_load = 1'b1;
            end
            OP_STR: begin
                // store data register lives in the rd field
                o_ctrl.rt       = i_insn.r.rd;
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
            end
            default: begin
                // unsupported opcode, all enables stay low
                o_ctrl.rs_re = 1'b0;
            end
        endcase
    end

endmodule

// ==== source/lc4_fetch.sv ====
/* fetch stage, instruction memory must return i_insn in the same cycle as o_pc
   a taken redirect overrides a stall */
`timescale 1ns/10ps

module lc4_fetch
    import lc4_pkg::*;
(
    input  logic      i_rst,
    input  logic      gwe,
    input  logic      i_stall,
    input  redirect_t i_redirect,
    input  insn_u     i_insn,
    output word_t     o_pc,
    output stage_t    o_fd
);

    word_t  pc_q;
    word_t  next_pc;
    stage_t fd_q;

    // redirect first, then hold on stall, else sequential
    always_comb begin
        if (i_redirect.taken) begin
            next_pc = i_redirect.target;
        end else if (i_stall) begin
            next_pc = pc_q;
        end else begin
            next_pc = pc_q + word_t'(1);
        end
    end

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            pc_q       <= RESET_PC;
            fd_q.valid <= 1'b0;
        end else begin
            pc_q <= next_pc;
            if (i_redirect.taken) begin
                // wrong-path fetch is dropped
                fd_q.valid <= 1'b0;
            end else if (!i_stall) begin
                // control is filled in by decode
                fd_q <= '{valid: 1'b1, pc: pc_q, insn: i_insn, ctrl: '0};
            end
        end
    end

    assign o_pc = pc_q;
    assign o_fd = fd_q;

endmodule

// ==== source/lc4_pkg.sv ====
/* shared widths, opcodes and pipeline types for the single-issue LC4 subset core
   slot payloads carry meaning only while the slot's valid bit is set */
package lc4_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_SEL_W = 3;
    localparam int NZP_W     = 3;
    localparam int OPC_W     = 4;

    // first fetch address after reset
    localparam logic [WORD_W-1:0] RESET_PC = 16'h8200;

    // opcodes of the supported subset
    localparam logic [OPC_W-1:0] OP_BR    = 4'b0000;
    localparam logic [OPC_W-1:0] OP_ADD   = 4'b0001;
    localparam logic [OPC_W-1:0] OP_AND   = 4'b0101;
    localparam logic [OPC_W-1:0] OP_LDR   = 4'b0110;
    localparam logic [OPC_W-1:0] OP_STR   = 4'b0111;
    localparam logic [OPC_W-1:0] OP_CONST = 4'b1001;
    localparam logic [OPC_W-1:0] OP_JMP   = 4'b1100;

    typedef logic [WORD_W-1:0] word_t;

    // register form, sub-op 000 selects plain ADD or AND
    typedef struct packed {
        logic [OPC_W-1:0]     opcode;
        logic [REG_SEL_W-1:0] rd;
        logic [REG_SEL_W-1:0] rs;
        logic [2:0]           sub;
        logic [REG_SEL_W-1:0] rt;
    } insn_reg_t;

    // immediate form, flag and imm5 also give the 6-bit LDR/STR offset
    typedef struct packed {
        logic [OPC_W-1:0]     opcode;
        logic [REG_SEL_W-1:0] rd;
        logic [REG_SEL_W-1:0] rs;
        logic                 imm_flag;
        logic [4:0]           imm5;
    } insn_imm_t;

    // branch form, also CONST imm9 and the JMP offset
    typedef struct packed {
        logic [OPC_W-1:0] opcode;
        logic [NZP_W-1:0] nzp;
        logic [8:0]       off9;
    } insn_br_t;

    // one instruction word seen through three field layouts
    typedef union packed {
        insn_reg_t r;
        insn_imm_t i;
        insn_br_t  b;
    } insn_u;

    typedef struct packed {
        logic [REG_SEL_W-1:0] rs;
        logic [REG_SEL_W-1:0] rt;
        logic [REG_SEL_W-1:0] rd;
        logic rs_re;
        logic rt_re;
        logic reg_we;
        logic nzp_we;
        logic is_load;
        logic is_store;
        logic is_branch;
        logic is_jump;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        insn_u insn;
        ctrl_t ctrl;
    } stage_t;

    // bypass source, doubles as the regfile write port
    typedef struct packed {
        logic                 we;
        logic [REG_SEL_W-1:0] sel;
        word_t                data;
    } fwd_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

    typedef struct packed {
        logic                 valid;
        word_t                pc;
        insn_u                insn;
        logic                 reg_we;
        logic [REG_SEL_W-1:0] wsel;
        word_t                wdata;
        logic                 nzp_we;
        logic [NZP_W-1:0]     nzp;
    } retire_t;

endpackage
